// File: common/frontend_pkg.sv
package frontend_pkg;

  localparam int XLEN          = 32;
  localparam int CACHE_ENTRIES = 8;
  localparam int INDEX_W       = 3;
  localparam int PLRU_BITS     = 7;   // CACHE_ENTRIES - 1 tree nodes
  localparam int REG_W         = 5;

  localparam logic [XLEN-1:0] PC_STEP  = 32'd4;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // RV32I major opcodes, low 7 bits of the word
  typedef enum logic [6:0] {
    illegal = 7'b0000000,
    load    = 7'b0000011,
    op_imm  = 7'b0010011,
    auipc   = 7'b0010111,
    store   = 7'b0100011,
    op      = 7'b0110011,
    lui     = 7'b0110111,
    branch  = 7'b1100011,
    jalr    = 7'b1100111,
    jal     = 7'b1101111,
    system  = 7'b1110011
  } opcode_e;

  typedef enum logic [1:0] {
    idle,
    request,
    wait_data,
    write
  } fill_state_e;

  typedef struct packed {
    opcode_e           opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [XLEN-1:0]   imm;
    logic [5:0]        shamt;
    logic [REG_W-1:0]  rs1;
    logic [REG_W-1:0]  rs2;
    logic [REG_W-1:0]  rd;
  } decoded_ins_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   word;
    decoded_ins_t      ins;
  } issue_t;

  typedef struct packed {
    logic              req;
    logic [XLEN-1:0]   addr;
  } mem_req_t;

endpackage

// File: icache/plru_tree.sv
`timescale 1ns/10ps

module plru_tree (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic                                rdy_in,
  input  logic                                access_valid,
  input  logic [frontend_pkg::INDEX_W-1:0]    access_index,
  output logic [frontend_pkg::INDEX_W-1:0]    victim_index
);

  // Node n has children 2n+1 (left) and 2n+2 (right); a set bit points right
  logic [frontend_pkg::PLRU_BITS-1:0] node_q;
  logic [frontend_pkg::PLRU_BITS-1:0] node_d;

  always_comb
  begin : find_victim
    int node;
    node         = 0;
    victim_index = '0;
    for (int lvl = 0; lvl < frontend_pkg::INDEX_W; lvl++)
    begin
      victim_index[frontend_pkg::INDEX_W-1-lvl] = node_q[node];
      node = node_q[node] ? 2 * node + 2 : 2 * node + 1;
    end
  end

  always_comb
  begin : touch_path
    int node;
    node   = 0;
    node_d = node_q;
    for (int lvl = 0; lvl < frontend_pkg::INDEX_W; lvl++)
    begin
      node_d[node] = ~access_index[frontend_pkg::INDEX_W-1-lvl];   // Away from accessed leaf
      node = access_index[frontend_pkg::INDEX_W-1-lvl] ? 2 * node + 2 : 2 * node + 1;
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
      node_q <= '0;
    else if (rdy_in && access_valid)
      node_q <= node_d;
  end

endmodule

// File: icache/ins_cache.sv
`timescale 1ns/10ps

module ins_cache (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic                                rdy_in,
  input  logic                                fetch_req,
  input  logic [frontend_pkg::XLEN-1:0]       fetch_addr,
  output logic                                fetch_ready,
  output logic [frontend_pkg::XLEN-1:0]       fetch_word,
  input  logic                                mem_accept,
  input  logic                                mem_valid,
  input  logic [frontend_pkg::XLEN-1:0]       mem_data,
  output frontend_pkg::mem_req_t              mem_out
);

  frontend_pkg::fill_state_e                    state;
  logic [frontend_pkg::CACHE_ENTRIES-1:0]       valid_q;
  logic [frontend_pkg::XLEN-1:2]                tag_mem  [frontend_pkg::CACHE_ENTRIES];
  logic [frontend_pkg::XLEN-1:0]                data_mem [frontend_pkg::CACHE_ENTRIES];
  logic [frontend_pkg::XLEN-1:2]                miss_tag;
  logic                                         hit;
  logic [frontend_pkg::INDEX_W-1:0]             hit_index;
  logic [frontend_pkg::INDEX_W-1:0]             fill_index;
  logic [frontend_pkg::INDEX_W-1:0]             victim_index;
  logic                                         lookup;
  logic                                         fill_write;

  assign lookup     = (state == frontend_pkg::idle) && fetch_req;
  assign fill_write = (state == frontend_pkg::wait_data) && mem_valid;

  assign mem_out.req  = (state == frontend_pkg::request);
  assign mem_out.addr = {miss_tag, 2'b00};

  // Fully associative compare on word address
  always_comb
  begin
    hit       = 1'b0;
    hit_index = '0;
    for (int i = 0; i < frontend_pkg::CACHE_ENTRIES; i++)
    begin
      if (valid_q[i] && (tag_mem[i] == fetch_addr[frontend_pkg::XLEN-1:2]))
      begin
        hit       = 1'b1;
        hit_index = i[frontend_pkg::INDEX_W-1:0];
      end
    end
  end

  // Lowest invalid entry wins over the PLRU victim
  always_comb
  begin
    fill_index = victim_index;
    for (int i = frontend_pkg::CACHE_ENTRIES - 1; i >= 0; i--)
    begin
      if (!valid_q[i])
        fill_index = i[frontend_pkg::INDEX_W-1:0];
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      state       <= frontend_pkg::idle;
      valid_q     <= '0;
      fetch_ready <= 1'b0;
    end
    else if (rdy_in)
    begin
      fetch_ready <= 1'b0;
      case (state)
        frontend_pkg::idle:
        begin
          if (lookup && hit)
            fetch_ready <= 1'b1;
          else if (lookup)
            state <= frontend_pkg::request;
        end
        frontend_pkg::request:
        begin
          if (mem_accept)
            state <= frontend_pkg::wait_data;
        end
        frontend_pkg::wait_data:
        begin
          if (mem_valid)
          begin
            state               <= frontend_pkg::write;
            valid_q[fill_index] <= 1'b1;
            fetch_ready         <= 1'b1;
          end
        end
        frontend_pkg::write:
          state <= frontend_pkg::idle;   // Ready cycle of the refill
      endcase
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rdy_in)
    begin
      if (lookup && hit)
        fetch_word <= data_mem[hit_index];
      if (lookup && !hit)
        miss_tag <= fetch_addr[frontend_pkg::XLEN-1:2];
      if (fill_write)
      begin
        tag_mem[fill_index]  <= miss_tag;
        data_mem[fill_index] <= mem_data;
        fetch_word           <= mem_data;   // Forward refill word
      end
    end
  end

  plru_tree u_plru (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .access_valid ((lookup && hit) || fill_write),
    .access_index (fill_write ? fill_index : hit_index),
    .victim_index (victim_index)
  );

endmodule

// File: design/ins_decoder.sv
`timescale 1ns/10ps

module ins_decoder (
  input  logic [frontend_pkg::XLEN-1:0]       word,
  output frontend_pkg::decoded_ins_t          decoded
);

  frontend_pkg::opcode_e          raw_op;
  frontend_pkg::opcode_e          opc;
  logic                           is_shift;
  logic [frontend_pkg::XLEN-1:0]  imm_i;
  logic [frontend_pkg::XLEN-1:0]  imm_s;
  logic [frontend_pkg::XLEN-1:0]  imm_b;
  logic [frontend_pkg::XLEN-1:0]  imm_u;
  logic [frontend_pkg::XLEN-1:0]  imm_j;

  assign raw_op   = frontend_pkg::opcode_e'(word[6:0]);
  assign is_shift = (opc == frontend_pkg::op_imm) && (word[13:12] == 2'b01);   // funct3 001/101

  assign imm_i = {{20{word[31]}}, word[31:20]};
  assign imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
  assign imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
  assign imm_u = {word[31:12], 12'b0};
  assign imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

  always_comb
  begin
    case (raw_op)
      frontend_pkg::op, frontend_pkg::op_imm, frontend_pkg::load, frontend_pkg::store,
      frontend_pkg::branch, frontend_pkg::jal, frontend_pkg::jalr, frontend_pkg::lui,
      frontend_pkg::auipc, frontend_pkg::system:
        opc = raw_op;
      default:
        opc = frontend_pkg::illegal;
    endcase
  end

  always_comb
  begin
    decoded        = '0;
    decoded.opcode = opc;
    // funct3 for every form but U and J
    if (!(opc == frontend_pkg::lui || opc == frontend_pkg::auipc ||
          opc == frontend_pkg::jal || opc == frontend_pkg::illegal))
      decoded.funct3 = word[14:12];
    if (opc == frontend_pkg::op || is_shift)
      decoded.funct7 = word[31:25];
    if (is_shift)
      decoded.shamt = word[25:20];
    case (opc)
      frontend_pkg::op_imm, frontend_pkg::load, frontend_pkg::jalr, frontend_pkg::system:
        decoded.imm = imm_i;
      frontend_pkg::store:
        decoded.imm = imm_s;
      frontend_pkg::branch:
        decoded.imm = imm_b;
      frontend_pkg::lui, frontend_pkg::auipc:
        decoded.imm = imm_u;
      frontend_pkg::jal:
        decoded.imm = imm_j;
      default:
        decoded.imm = '0;   // R form and illegal
    endcase
    if (!(opc == frontend_pkg::store || opc == frontend_pkg::branch ||
          opc == frontend_pkg::illegal))
      decoded.rd = word[11:7];
    if (!(opc == frontend_pkg::lui || opc == frontend_pkg::auipc ||
          opc == frontend_pkg::jal || opc == frontend_pkg::illegal))
      decoded.rs1 = word[19:15];
    if (opc == frontend_pkg::op || opc == frontend_pkg::store || opc == frontend_pkg::branch)
      decoded.rs2 = word[24:20];
  end

endmodule

// File: design/issue_stage.sv
`timescale 1ns/10ps

module issue_stage (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic                                rdy_in,
  input  logic                                redirect_valid,
  input  logic [frontend_pkg::XLEN-1:0]       redirect_pc,
  input  logic                                fetch_ready,
  input  logic [frontend_pkg::XLEN-1:0]       fetch_word,
  input  frontend_pkg::decoded_ins_t          decoded,
  output logic                                fetch_req,
  output logic [frontend_pkg::XLEN-1:0]       fetch_addr,
  output logic                                issue_valid,
  output frontend_pkg::issue_t                issue_out
);

  logic                           run_q;
  logic                           cancel_q;   // In-flight fetch belongs to the old path
  logic [frontend_pkg::XLEN-1:0]  pc_q;

  // Held until the cache answers, dropped for the ready cycle
  assign fetch_req  = run_q && !fetch_ready;
  assign fetch_addr = pc_q;

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      run_q       <= 1'b0;
      cancel_q    <= 1'b0;
      pc_q        <= frontend_pkg::RESET_PC;
      issue_valid <= 1'b0;
    end
    else if (rdy_in)
    begin
      run_q       <= 1'b1;
      issue_valid <= 1'b0;
      if (redirect_valid)
      begin
        pc_q     <= redirect_pc;
        cancel_q <= fetch_req;
      end
      else if (fetch_ready)
      begin
        cancel_q <= 1'b0;
        if (!cancel_q)
        begin
          issue_valid <= 1'b1;
          pc_q        <= pc_q + frontend_pkg::PC_STEP;
        end
      end
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rdy_in && fetch_ready && !cancel_q && !redirect_valid)
    begin
      issue_out.pc   <= pc_q;
      issue_out.word <= fetch_word;
      issue_out.ins  <= decoded;
    end
  end

endmodule

// File: design/frontend_top.sv
`timescale 1ns/10ps

module frontend_top (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic                                rdy_in,
  input  logic                                redirect_valid,
  input  logic [frontend_pkg::XLEN-1:0]       redirect_pc,
  input  logic                                mem_accept,
  input  logic                                mem_valid,
  input  logic [frontend_pkg::XLEN-1:0]       mem_data,
  output frontend_pkg::mem_req_t              mem_out,
  output logic                                issue_valid,
  output frontend_pkg::issue_t                issue_out
);

  logic                           fetch_req;
  logic [frontend_pkg::XLEN-1:0]  fetch_addr;
  logic                           fetch_ready;
  logic [frontend_pkg::XLEN-1:0]  fetch_word;
  frontend_pkg::decoded_ins_t     decoded;

  issue_stage u_issue (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .fetch_ready    (fetch_ready),
    .fetch_word     (fetch_word),
    .decoded        (decoded),
    .fetch_req      (fetch_req),
    .fetch_addr     (fetch_addr),
    .issue_valid    (issue_valid),
    .issue_out      (issue_out)
  );

  ins_cache u_cache (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .fetch_word  (fetch_word),
    .mem_accept  (mem_accept),
    .mem_valid   (mem_valid),
    .mem_data    (mem_data),
    .mem_out     (mem_out)
  );

  ins_decoder u_decoder (
    .word    (fetch_word),
    .decoded (decoded)
  );

endmodule

// File: verif/frontend_props.sv
`timescale 1ns/10ps

module frontend_props (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        rdy_in,
  input  logic                        fetch_req,
  input  logic                        hit,
  input  logic                        fetch_ready,
  input  logic                        mem_accept,
  input  frontend_pkg::mem_req_t      mem_out,
  input  frontend_pkg::fill_state_e   state
);

  ready_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    (fetch_ready && rdy_in) |=> !fetch_ready)
    else $error("fetch_ready high in two consecutive cycles");

  // Address held until the adaptor accepts
  req_addr_stable: assert property (@(posedge clk_in) disable iff (rst_in)
    (mem_out.req && !mem_accept) |=> $stable(mem_out.addr))
    else $error("mem_out.addr changed while waiting for accept");

  idle_on_no_miss: assert property (@(posedge clk_in) disable iff (rst_in)
    (state == frontend_pkg::idle && !(fetch_req && !hit)) |=> state == frontend_pkg::idle)
    else $error("cache left idle without a missing request");

endmodule

bind ins_cache frontend_props u_props (
  .clk_in      (clk_in),
  .rst_in      (rst_in),
  .rdy_in      (rdy_in),
  .fetch_req   (fetch_req),
  .hit         (hit),
  .fetch_ready (fetch_ready),
  .mem_accept  (mem_accept),
  .mem_out     (mem_out),
  .state       (state)
);

// File: verif/tb_frontend.sv
`timescale 1ns/10ps

module tb_frontend;

  logic                                 clk_in;
  logic                                 rst_in;
  logic                                 rdy_in;
  logic                                 redirect_valid;
  logic [frontend_pkg::XLEN-1:0]        redirect_pc;
  logic                                 mem_accept;
  logic                                 mem_valid;
  logic [frontend_pkg::XLEN-1:0]        mem_data;
  frontend_pkg::mem_req_t               mem_out;
  logic                                 issue_valid;
  frontend_pkg::issue_t                 issue_out;

  logic [31:0]                          img_word [64];   // Indexed by word address
  frontend_pkg::decoded_ins_t           exp_dec  [64];
  int                                   redir_count [$];
  logic [31:0]                          redir_target [$];
  logic [31:0]                          exp_req [$];
  logic [31:0]                          seen_req [$];
  int                                   pause_at;
  int                                   pause_len;
  int                                   total_issues;

  frontend_top DUT (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .mem_accept     (mem_accept),
    .mem_valid      (mem_valid),
    .mem_data       (mem_data),
    .mem_out        (mem_out),
    .issue_valid    (issue_valid),
    .issue_out      (issue_out)
  );

  initial
  begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  // addi x0, x0, addr for words the vectors leave out
  task automatic fill_memory();
    for (int i = 0; i < 64; i++)
      img_word[i] = {12'(i * 4), 20'h00013};
  endtask

  task automatic read_vectors();
    int          fd;
    int          n;
    int          cnt;
    string       line;
    logic [31:0] a, w, opc, f3, f7, imm, sh, r1, r2, rd;
    fd = $fopen("verif/frontend_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the vector file verif/frontend_vectors.txt");
      $display("Finished with errors");
      $fatal(1, "No vectors");
    end
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 1)
      begin
        case (line.getc(0))
          "D":
          begin
            n = $sscanf(line, "D %h %h %h %h %h %h %h %h %h %h",
                        a, w, opc, f3, f7, imm, sh, r1, r2, rd);
            img_word[a[7:2]]        = w;
            exp_dec[a[7:2]].opcode  = frontend_pkg::opcode_e'(opc[6:0]);
            exp_dec[a[7:2]].funct3  = f3[2:0];
            exp_dec[a[7:2]].funct7  = f7[6:0];
            exp_dec[a[7:2]].imm     = imm;
            exp_dec[a[7:2]].shamt   = sh[5:0];
            exp_dec[a[7:2]].rs1     = r1[4:0];
            exp_dec[a[7:2]].rs2     = r2[4:0];
            exp_dec[a[7:2]].rd      = rd[4:0];
          end
          "R":
          begin
            n = $sscanf(line, "R %d %h", cnt, a);
            redir_count.push_back(cnt);
            redir_target.push_back(a);
          end
          "P":
            n = $sscanf(line, "P %d %d", pause_at, pause_len);
          "Q":
          begin
            n = $sscanf(line, "Q %h", a);
            exp_req.push_back(a);
          end
          "N":
            n = $sscanf(line, "N %d", total_issues);
          default:
            n = 0;   // Comment line
        endcase
      end
    end
    $fclose(fd);
  endtask

  initial
  begin
    int          cycles;
    int          issued;
    int          limit;
    int          mem_cnt;
    int          pause_left;
    bit          busy;
    bit          pause_pending;
    bit          do_redirect;
    string       tname;
    logic [31:0] exp_pc;
    logic [31:0] req_addr;
    logic [5:0]  idx;
    rst_in         = 1'b1;
    rdy_in         = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    mem_accept     = 1'b0;
    mem_valid      = 1'b0;
    mem_data       = '0;
    fill_memory();
    read_vectors();
    cycles        = 0;
    issued        = 0;
    mem_cnt       = 0;
    pause_left    = 0;
    busy          = 1'b0;
    pause_pending = 1'b0;
    req_addr      = '0;
    exp_pc        = frontend_pkg::RESET_PC;
    limit         = total_issues * 12 + 100;

    repeat (10)
    begin
      @(posedge clk_in);
      #2;
      check_value("reset issue_valid", 32'(0), 32'(issue_valid));
      check_value("reset mem_req", 32'(0), 32'(mem_out.req));
    end
    rst_in = 1'b0;
    @(posedge clk_in);
    #2;
    check_value("after reset issue_valid", 32'(0), 32'(issue_valid));
    check_value("after reset mem_req", 32'(0), 32'(mem_out.req));

    while (issued < total_issues)
    begin
      @(posedge clk_in);
      #2;
      cycles++;
      if (cycles > limit)
      begin
        $display("Timeout after %0d cycles with %0d of %0d issues", cycles, issued,
                 total_issues);
        $display("Finished with errors");
        $fatal(1, "Timeout");
      end
      do_redirect = 1'b0;
      if (issue_valid)
      begin
        idx   = exp_pc[7:2];
        tname = $sformatf("issue %0d", issued + 1);
        check_value({tname, " pc"}, exp_pc, issue_out.pc);
        check_value({tname, " word"}, img_word[idx], issue_out.word);
        check_value({tname, " opcode"}, 32'(exp_dec[idx].opcode), 32'(issue_out.ins.opcode));
        check_value({tname, " funct3"}, 32'(exp_dec[idx].funct3), 32'(issue_out.ins.funct3));
        check_value({tname, " funct7"}, 32'(exp_dec[idx].funct7), 32'(issue_out.ins.funct7));
        check_value({tname, " imm"}, exp_dec[idx].imm, issue_out.ins.imm);
        check_value({tname, " shamt"}, 32'(exp_dec[idx].shamt), 32'(issue_out.ins.shamt));
        check_value({tname, " rs1"}, 32'(exp_dec[idx].rs1), 32'(issue_out.ins.rs1));
        check_value({tname, " rs2"}, 32'(exp_dec[idx].rs2), 32'(issue_out.ins.rs2));
        check_value({tname, " rd"}, 32'(exp_dec[idx].rd), 32'(issue_out.ins.rd));
        issued++;
        exp_pc = exp_pc + frontend_pkg::PC_STEP;
        if (redir_count.size() > 0 && redir_count[0] == issued)
        begin
          do_redirect = 1'b1;
          exp_pc      = redir_target[0];   // Next issue comes from the target
          redirect_pc = redir_target.pop_front();
          redir_count.pop_front();
        end
        if (issued == pause_at)
          pause_pending = 1'b1;
      end

      // Pause starts once issue_valid has dropped
      if (pause_left > 0)
      begin
        rdy_in = 1'b0;
        pause_left--;
      end
      else if (pause_pending && !issue_valid)
      begin
        pause_pending = 1'b0;
        pause_left    = pause_len - 1;
        rdy_in        = 1'b0;
      end
      else
        rdy_in = 1'b1;
      if (!rdy_in)
        check_value("pause issue_valid", 32'(0), 32'(issue_valid));

      // Memory adaptor model
      mem_accept = 1'b0;
      mem_valid  = 1'b0;
      if (rdy_in && busy)
      begin
        mem_cnt++;
        if (mem_cnt == 1)
          mem_accept = 1'b1;
        else if (mem_cnt == 4)
        begin
          mem_valid = 1'b1;
          mem_data  = img_word[req_addr[7:2]];
          busy      = 1'b0;
        end
      end
      if (!busy && mem_out.req)
      begin
        req_addr = mem_out.addr;
        seen_req.push_back(req_addr);
        check_value("request address range", 32'(0), 32'(req_addr[31:8]));
        busy    = 1'b1;
        mem_cnt = 0;
      end

      redirect_valid = do_redirect;
    end

    check_value("request count", 32'(exp_req.size()), 32'(seen_req.size()));
    for (int i = 0; i < exp_req.size(); i++)
      check_value($sformatf("request %0d addr", i + 1), exp_req[i], seen_req[i]);
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: verif/frontend_vectors.txt
# D addr word opcode funct3 funct7 imm shamt rs1 rs2 rd (hex), R issue_count target
# P issue_count cycles, N total_issues (decimal counts), Q expected request address
D 00 ffb00093 13 0 00 fffffffb 00 00 00 01
D 04 00309113 13 1 00 00000003 03 01 00 02
D 08 402081b3 33 0 20 00000000 00 01 02 03
D 0c ff812203 03 2 00 fffffff8 00 02 00 04
D 10 fe312e23 23 2 00 fffffffc 00 02 03 00
D 14 fe2088e3 63 0 00 fffffff0 00 01 02 00
D 18 123452b7 37 0 00 12345000 00 00 00 05
D 1c fffff317 17 0 00 fffff000 00 00 00 06
D 20 ff9ff0ef 6f 0 00 fffffff8 00 00 00 01
D 24 00100493 13 0 00 00000001 00 00 00 09
D 40 00c08067 67 0 00 0000000c 00 01 00 00
D 44 4041d393 13 5 20 00000404 04 03 00 07
D 48 3000a473 73 2 00 00000300 00 01 00 08
D 4c ffffffff 00 0 00 00000000 00 00 00 00
R 7 00000000
R 16 00000000
R 18 00000040
P 10 6
N 22
Q 00000000
Q 00000004
Q 00000008
Q 0000000c
Q 00000010
Q 00000014
Q 00000018
Q 0000001c
Q 00000020
Q 00000024
Q 00000000
Q 00000008
Q 00000040
Q 00000044
Q 00000048
Q 0000004c

// File: compile.f
common/frontend_pkg.sv
icache/plru_tree.sv
icache/ins_cache.sv
design/ins_decoder.sv
design/issue_stage.sv
design/frontend_top.sv
verif/frontend_props.sv
verif/tb_frontend.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the pass line
rm -f sim.log && verilator --binary --timing --assert --top-module tb_frontend \
  -f compile.f -o tb_frontend_sim && ./obj_dir/tb_frontend_sim > sim.log 2>&1
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
